// File: pwm_bank.f
design/pwm_event_pkg.sv
design/pwm_timer_pkg.sv
design/pwm_carrier.sv
design/pwm_compare_dt.sv
design/pwm_interrupt_matrix.sv
design/pwm_channel_bank.sv
+incdir+verification
verification/pwm_bank_tb.sv

// File: Makefile
# build and run the pwm channel bank testbench with verilator

sim:
	verilator --binary --timescale 1ns/1ps --top-module pwm_bank_tb -Mdir obj_dir -f pwm_bank.f
	./obj_dir/Vpwm_bank_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: verification/pwm_bank_tb_table.svh
// columns: kind, channel, pwm_on, int_matrix, window clocks, pwm_a and pwm_b high clocks,
// trigger spacing or interrupt hold clocks, then the channel cfg
// cfg: carrier_on, dt_on, logic_a, logic_b, count mode, mask mode,
//      period, init_value, compare, dtime_a, dtime_b, event_count
localparam int num_rows = 13;

localparam test_row_t table_rows [num_rows] = '{
    // up mode, a active compare clocks, b the rest
    '{row_duty, 0, 1'b1, 4'b0000, 10, 4, 6, 0,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_up, event_zero,
        16'd9, 16'd0, 16'd4, 8'd0, 8'd0, 3'd0}},
    // dead time shortens each active phase
    '{row_duty, 2, 1'b1, 4'b0000, 20, 7, 8, 0,
      '{1'b1, 1'b1, 1'b1, 1'b1, count_up, event_zero,
        16'd19, 16'd0, 16'd10, 8'd3, 8'd2, 3'd0}},
    // a active low, so high clocks are the inactive ones
    '{row_duty, 0, 1'b1, 4'b0000, 10, 7, 7, 0,
      '{1'b1, 1'b0, 1'b0, 1'b1, count_up, event_zero,
        16'd9, 16'd0, 16'd3, 8'd0, 8'd0, 3'd0}},
    '{row_duty, 1, 1'b1, 4'b0000, 16, 12, 9, 0,
      '{1'b1, 1'b1, 1'b0, 1'b0, count_up, event_zero,
        16'd15, 16'd0, 16'd6, 8'd2, 8'd3, 3'd0}},
    // stopped by the channel bit, then by the global enable
    '{row_duty, 2, 1'b1, 4'b0000, 16, 0, 16, 0,
      '{1'b0, 1'b0, 1'b1, 1'b0, count_up, event_zero,
        16'd15, 16'd0, 16'd8, 8'd0, 8'd0, 3'd0}},
    '{row_duty, 3, 1'b0, 4'b0000, 16, 16, 0, 0,
      '{1'b1, 1'b0, 1'b0, 1'b1, count_up, event_zero,
        16'd15, 16'd0, 16'd8, 8'd0, 8'd0, 3'd0}},
    // up-down, 2*period clocks per cycle
    '{row_duty, 0, 1'b1, 4'b0000, 20, 7, 13, 0,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_updown, event_zero,
        16'd10, 16'd0, 16'd4, 8'd0, 8'd0, 3'd0}},
    '{row_duty, 2, 1'b1, 4'b0000, 32, 31, 1, 0,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_updown, event_both,
        16'd16, 16'd0, 16'd16, 8'd0, 8'd0, 3'd0}},
    // down mode from a phase shifted start
    '{row_duty, 1, 1'b1, 4'b0000, 12, 5, 7, 0,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_down, event_zero,
        16'd11, 16'd3, 16'd5, 8'd0, 8'd0, 3'd0}},
    // trigger spacing (event_count+1)*(period+1)
    '{row_trig_gap, 0, 1'b1, 4'b0001, 24, 0, 0, 24,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_up, event_zero,
        16'd7, 16'd0, 16'd3, 8'd0, 8'd0, 3'd2}},
    '{row_trig_gap, 3, 1'b1, 4'b1000, 5, 0, 0, 5,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_up, event_zero,
        16'd4, 16'd0, 16'd2, 8'd0, 8'd0, 3'd0}},
    // events of a channel left out of the matrix
    '{row_trig_none, 2, 1'b1, 4'b1011, 30, 0, 0, 0,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_up, event_both,
        16'd5, 16'd0, 16'd2, 8'd0, 8'd0, 3'd0}},
    // interrupt holds 25 idle clocks before ack
    '{row_irq, 1, 1'b1, 4'b0010, 12, 0, 0, 25,
      '{1'b1, 1'b0, 1'b1, 1'b1, count_up, event_period,
        16'd5, 16'd0, 16'd2, 8'd0, 8'd0, 3'd1}}
};

// File: verification/pwm_bank_tb.sv
`default_nettype none

module pwm_bank_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import pwm_timer_pkg::*;
    import pwm_event_pkg::*;

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;

    // what a table row measures
    typedef enum logic [1:0] {
        row_duty,
        row_trig_gap,
        row_trig_none,
        row_irq
    } row_kind_t;

    // stimulus of one row and the values it should give
    typedef struct packed {
        row_kind_t     kind;
        int            chan;
        logic          pwm_on;
        channel_mask_t int_matrix;
        int            window;     // one carrier cycle, or one event spacing
        int            exp_a;      // clocks with pwm_a high per window
        int            exp_b;
        int            exp_gap;    // trigger spacing, or interrupt hold clocks
        pwm_chan_cfg_t cfg;
    } test_row_t;

    `include "pwm_bank_tb_table.svh"

    logic                             clk;
    logic                             reset;
    pwm_chan_cfg_t [num_channels-1:0] cfg;
    logic                             pwm_on;
    channel_mask_t                    int_matrix;
    logic                             int_ack;
    channel_mask_t                    pwm_a;
    channel_mask_t                    pwm_b;
    logic                             trigger;
    logic                             interrupt;

    int          error_count;
    int          check_count;
    int          timeout_count;
    logic [31:0] lcg_state;

    pwm_channel_bank dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // lcg step, full 32 bit state
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("ERR %0d ns: %s, got %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0d ns while waiting for %s", $time, what);
    endtask

    // stop every channel, then clear what is still pending
    task automatic clear_bank();
        pwm_on = 1'b0;
        @(negedge clk);
        int_ack = 1'b1;
        @(negedge clk);
        int_ack = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic apply_row(input test_row_t row);
        for (int i = 0; i < num_channels; i++) begin
            if (i == row.chan) begin
                cfg[i] = row.cfg;
            end else begin
                // idle channel, random phase it never uses
                lcg_state = lcg_next(lcg_state);
                cfg[i] = '0;
                cfg[i].logic_a = 1'b1;
                cfg[i].logic_b = 1'b1;
                cfg[i].init_value = lcg_state[23:8];
            end
        end
        int_matrix = row.int_matrix;
        // one stopped clock loads init_value before the start
        @(negedge clk);
        pwm_on = row.pwm_on;
    endtask

    // ------------------------------------------------------------
    // measurements
    // ------------------------------------------------------------

    // high clocks of the pair, overlap and trigger pulses over one window
    task automatic measure_window(input test_row_t row);
        int            a_high;
        int            b_high;
        int            overlap;
        int            pulses;
        channel_mask_t others;
        a_high = 0;
        b_high = 0;
        overlap = 0;
        pulses = 0;
        others = '1;
        others[row.chan] = 1'b0;
        for (int n = 0; n < row.window; n++) begin
            @(negedge clk);
            a_high += int'(pwm_a[row.chan]);
            b_high += int'(pwm_b[row.chan]);
            overlap += int'(pwm_a[row.chan] == row.cfg.logic_a
                            && pwm_b[row.chan] == row.cfg.logic_b);
            pulses += int'(trigger);
        end
        if (row.kind == row_duty) begin
            check_value("pwm_a high clocks", a_high, row.exp_a);
            check_value("pwm_b high clocks", b_high, row.exp_b);
            check_value("clocks with a and b both active", overlap, 0);
            // stopped channels rest low
            check_value("idle channel outputs", int'((pwm_a | pwm_b) & others), 0);
        end else begin
            check_value("trigger pulses with matrix bit clear", pulses, 0);
            check_value("interrupt with matrix bit clear", int'(interrupt), 0);
        end
    endtask

    task automatic measure_trigger_gap(input test_row_t row);
        int   gap;
        logic seen;
        gap = 0;
        seen = 1'b0;
        for (int n = 0; n < 4 * row.window + 20 && !seen; n++) begin
            @(negedge clk);
            seen = trigger;
        end
        if (!seen) begin
            report_timeout("a first trigger pulse");
        end else begin
            seen = 1'b0;
            for (int n = 0; n < 4 * row.window + 20 && !seen; n++) begin
                @(negedge clk);
                gap++;
                seen = trigger;
            end
            if (!seen) begin
                report_timeout("the next trigger pulse");
            end else begin
                check_value("clocks between trigger pulses", gap, row.exp_gap);
            end
        end
    endtask

    task automatic check_interrupt_hold(input test_row_t row);
        int   held;
        int   clocks;
        logic seen;
        held = 0;
        clocks = 0;
        seen = 1'b0;
        for (int n = 0; n < 4 * row.window + 20 && !seen; n++) begin
            @(negedge clk);
            seen = interrupt;
        end
        if (!seen) begin
            report_timeout("the interrupt to rise");
        end else begin
            // no more events, level has to hold on its own
            pwm_on = 1'b0;
            for (int n = 0; n < row.exp_gap; n++) begin
                @(negedge clk);
                held += int'(interrupt);
            end
            check_value("interrupt clocks held without ack", held, row.exp_gap);
            int_ack = 1'b1;
            seen = 1'b0;
            for (int n = 0; n < 8 && !seen; n++) begin
                @(negedge clk);
                int_ack = 1'b0;
                clocks++;
                seen = !interrupt;
            end
            if (!seen) begin
                report_timeout("the interrupt to clear after ack");
            end else begin
                check_value("interrupt low within two clocks of ack", int'(clocks <= 2), 1);
            end
        end
    endtask

    task automatic run_row(input int index, input test_row_t row);
        int failures_before;
        failures_before = error_count + timeout_count;
        clear_bank();
        apply_row(row);
        // two carrier cycles to settle
        repeat (2 * row.window) @(negedge clk);
        case (row.kind)
            row_duty:     measure_window(row);
            row_trig_gap: measure_trigger_gap(row);
            row_irq:      check_interrupt_hold(row);
            default:      measure_window(row);
        endcase
        $display("row %0d %s on channel %0d: %s", index, row.kind.name(), row.chan,
                 (error_count + timeout_count == failures_before) ? "ok" : "mismatch");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        error_count = 0;
        check_count = 0;
        timeout_count = 0;
        lcg_state = 32'hd46b;
        reset = 1'b1;
        pwm_on = 1'b0;
        int_matrix = '0;
        int_ack = 1'b0;
        for (int i = 0; i < num_channels; i++) begin
            cfg[i] = '0;
            cfg[i].logic_a = 1'b1;
            cfg[i].logic_b = 1'b1;
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        check_value("trigger after reset", int'(trigger), 0);
        check_value("interrupt after reset", int'(interrupt), 0);
        check_value("outputs after reset", int'(pwm_a | pwm_b), 0);
        for (int r = 0; r < num_rows; r++) begin
            run_row(r, table_rows[r]);
        end
        $display("rows %0d, checks %0d, errors %0d, timeouts %0d",
                 num_rows, check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/pwm_channel_bank.sv
`default_nettype none

module pwm_channel_bank (
    input  logic                                                       clk,
    input  logic                                                       reset,
    input  pwm_timer_pkg::pwm_chan_cfg_t [pwm_event_pkg::num_channels-1:0] cfg,
    input  logic                                                       pwm_on,
    input  pwm_event_pkg::channel_mask_t                               int_matrix,
    input  logic                                                       int_ack,
    output pwm_event_pkg::channel_mask_t                               pwm_a,
    output pwm_event_pkg::channel_mask_t                               pwm_b,
    output logic                                                       trigger,
    output logic                                                       interrupt
);

    import pwm_timer_pkg::*;
    import pwm_event_pkg::*;

    // per channel run level, global and channel enable together
    channel_mask_t run;
    // channel events gathered for the matrix
    channel_mask_t events;

    // ------------------------------------------------------------
    // channels, each on its own carrier
    // ------------------------------------------------------------
    for (genvar i = 0; i < num_channels; i++) begin : chan
        carrier_t carrier;

        assign run[i] = pwm_on && cfg[i].carrier_on;

        pwm_carrier u_carrier (
            .clk        (clk),
            .reset      (reset),
            .cfg        (cfg[i]),
            .run        (run[i]),
            .carrier    (carrier),
            .chan_event (events[i])
        );

        pwm_compare_dt u_compare (
            .clk     (clk),
            .reset   (reset),
            .cfg     (cfg[i]),
            .run     (run[i]),
            .carrier (carrier),
            .pwm_a   (pwm_a[i]),
            .pwm_b   (pwm_b[i])
        );
    end

    // shared trigger and interrupt
    pwm_interrupt_matrix u_int_matrix (
        .clk        (clk),
        .reset      (reset),
        .events     (events),
        .int_matrix (int_matrix),
        .int_ack    (int_ack),
        .trigger    (trigger),
        .interrupt  (interrupt)
    );

endmodule

`default_nettype wire

// File: design/pwm_interrupt_matrix.sv
`default_nettype none

module pwm_interrupt_matrix (
    input  logic                         clk,
    input  logic                         reset,
    input  pwm_event_pkg::channel_mask_t events,
    input  pwm_event_pkg::channel_mask_t int_matrix,
    input  logic                         int_ack,
    output logic                         trigger,
    output logic                         interrupt
);

    import pwm_event_pkg::*;

    // ------------------------------------------------------------
    // event selection
    // ------------------------------------------------------------

    // events routed to the interrupt side
    channel_mask_t selected;
    // one pending bit per channel
    channel_mask_t pending;

    assign selected = events & int_matrix;

    // ------------------------------------------------------------
    // pending latch, trigger and interrupt level
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            trigger <= 1'b0;
            interrupt <= 1'b0;
        end else begin
            // one cycle pulse after any selected event
            trigger <= |selected;
            // ack clears old bits, a new event in the same cycle wins
            if (int_ack) begin
                pending <= selected;
            end else begin
                pending <= pending | selected;
            end
            // level follows pending one clock later
            interrupt <= |pending;
        end
    end

endmodule

`default_nettype wire

// File: design/pwm_compare_dt.sv
`default_nettype none

module pwm_compare_dt (
    input  logic                        clk,
    input  logic                        reset,
    input  pwm_timer_pkg::pwm_chan_cfg_t cfg,
    input  logic                        run,
    input  pwm_timer_pkg::carrier_t     carrier,
    output logic                        pwm_a,
    output logic                        pwm_b
);

    import pwm_timer_pkg::*;

    // index 0 is output a, index 1 is output b
    localparam int out_a = 0;
    localparam int out_b = 1;

    // ------------------------------------------------------------
    // compare stage
    // ------------------------------------------------------------

    // carrier below compare, unregistered
    logic           below;
    // registered complementary pair, before dead time
    logic [1:0]     raw_q;

    // dead time stage
    dtime_t [1:0]   dt_load;
    dtime_t [1:0]   dt_cnt;
    // internal active high levels after dead time
    logic [1:0]     level;

    assign below = carrier < cfg.compare;

    // both raw levels low while stopped
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            raw_q <= '0;
        end else begin
            raw_q[out_a] <= below;
            raw_q[out_b] <= !below;
        end
    end

    // ------------------------------------------------------------
    // dead time insertion
    // ------------------------------------------------------------

    // separate delay for each rising edge
    assign dt_load[out_a] = cfg.dtime_a;
    assign dt_load[out_b] = cfg.dtime_b;

    // counter reloads while raw is low and counts down once raw rises
    // level goes high when it reaches zero, falls with raw at once
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (reset || !run) begin
                level[k] <= 1'b0;
                dt_cnt[k] <= '0;
            end else if (!raw_q[k]) begin
                // falling edge passes straight through
                level[k] <= 1'b0;
                dt_cnt[k] <= dt_load[k];
            end else if (!cfg.dt_on || dt_cnt[k] == '0) begin
                level[k] <= 1'b1;
            end else begin
                // hold back the rising edge
                dt_cnt[k] <= dt_cnt[k] - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // output polarity
    // ------------------------------------------------------------

    // logic bit 1 gives active high, 0 gives active low
    // so a stopped channel sits at the inverse of its logic bit
    assign pwm_a = cfg.logic_a ? level[out_a] : !level[out_a];
    assign pwm_b = cfg.logic_b ? level[out_b] : !level[out_b];

endmodule

`default_nettype wire

// File: design/pwm_carrier.sv
`default_nettype none

module pwm_carrier (
    input  logic                        clk,
    input  logic                        reset,
    input  pwm_timer_pkg::pwm_chan_cfg_t cfg,
    input  logic                        run,
    output pwm_timer_pkg::carrier_t     carrier,
    output logic                        chan_event
);

    import pwm_timer_pkg::*;
    import pwm_event_pkg::*;

    // ------------------------------------------------------------
    // carrier counter
    // ------------------------------------------------------------

    carrier_t     carrier_next;
    // up-down direction, 1 while counting down
    logic         dir_down;
    logic         dir_down_next;

    // raw event detection
    logic         at_zero;
    logic         at_period;
    logic         raw_event;

    // decimation counter
    event_count_t event_cnt;

    // next carrier value per count mode
    always_comb begin
        carrier_next = carrier;
        dir_down_next = dir_down;
        case (cfg.count_mode)
            count_down: begin
                // wrap back to period at zero
                // also catches an init value above period
                if (carrier == '0 || carrier > cfg.period) begin
                    carrier_next = cfg.period;
                end else begin
                    carrier_next = carrier - 1'b1;
                end
            end
            count_updown: begin
                if (!dir_down) begin
                    // turn around at the top
                    if (carrier >= cfg.period) begin
                        carrier_next = cfg.period - 1'b1;
                        dir_down_next = 1'b1;
                    end else begin
                        carrier_next = carrier + 1'b1;
                    end
                end else begin
                    // turn around at the bottom
                    if (carrier == '0) begin
                        carrier_next = carrier + 1'b1;
                        dir_down_next = 1'b0;
                    end else begin
                        carrier_next = carrier - 1'b1;
                    end
                end
            end
            default: begin
                // up mode, period+1 clocks per cycle
                if (carrier >= cfg.period) begin
                    carrier_next = '0;
                end else begin
                    carrier_next = carrier + 1'b1;
                end
            end
        endcase
    end

    // stopped channel holds init_value, ready for a phase shifted start
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            carrier <= cfg.init_value;
            dir_down <= 1'b0;
        end else begin
            carrier <= carrier_next;
            dir_down <= dir_down_next;
        end
    end

    // ------------------------------------------------------------
    // event detection and decimation
    // ------------------------------------------------------------

    // compare on the registered carrier
    assign at_zero = run && (carrier == '0);
    assign at_period = run && (carrier == cfg.period);

    always_comb begin
        case (cfg.mask_mode)
            event_zero:   raw_event = at_zero;
            event_period: raw_event = at_period;
            event_both:   raw_event = at_zero || at_period;
            default:      raw_event = 1'b0;
        endcase
    end

    // pulse after every (event_count+1)-th raw event, then restart
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            event_cnt <= '0;
            chan_event <= 1'b0;
        end else begin
            chan_event <= 1'b0;
            if (raw_event) begin
                if (event_cnt >= cfg.event_count) begin
                    event_cnt <= '0;
                    chan_event <= 1'b1;
                end else begin
                    event_cnt <= event_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pwm_timer_pkg.sv
`default_nettype none

package pwm_timer_pkg;

    // event counter type lives with the interrupt side
    import pwm_event_pkg::*;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // carrier, period and compare width
    localparam int carrier_width = 16;
    // dead time counter width, in clk cycles
    localparam int dtime_width = 8;

    typedef logic [carrier_width-1:0] carrier_t;
    typedef logic [dtime_width-1:0] dtime_t;

    // ------------------------------------------------------------
    // mode encodings
    // ------------------------------------------------------------

    // carrier count direction
    typedef enum logic [1:0] {
        count_up     = 2'd0,
        count_down   = 2'd1,
        count_updown = 2'd2
    } count_mode_t;

    // which carrier points raise a raw event
    typedef enum logic [1:0] {
        event_zero   = 2'd0,
        event_period = 2'd1,
        event_both   = 2'd2
    } mask_mode_t;

    // ------------------------------------------------------------
    // full setting of one channel
    // ------------------------------------------------------------
    typedef struct packed {
        logic         carrier_on;   // channel enable, anded with global pwm_on
        logic         dt_on;        // dead time insertion enable
        logic         logic_a;      // 1 = output a active high
        logic         logic_b;      // 1 = output b active high
        count_mode_t  count_mode;
        mask_mode_t   mask_mode;
        carrier_t     period;
        carrier_t     init_value;   // loaded while stopped, sets phase
        carrier_t     compare;
        dtime_t       dtime_a;      // delay on rising edge of a
        dtime_t       dtime_b;      // delay on rising edge of b
        event_count_t event_count;
    } pwm_chan_cfg_t;

endpackage

`default_nettype wire

// File: design/pwm_event_pkg.sv
`default_nettype none

package pwm_event_pkg;

    // ------------------------------------------------------------
    // channel bank size
    // ------------------------------------------------------------

    // number of pwm channels in the bank
    localparam int num_channels = 4;

    // ------------------------------------------------------------
    // event decimation and interrupt side
    // ------------------------------------------------------------

    // width of the per channel event decimation counter
    localparam int event_count_width = 3;

    // decimation value, event every (n+1) raw events
    typedef logic [event_count_width-1:0] event_count_t;

    // one bit per channel
    // used for channel events, matrix select and pending bits
    typedef logic [num_channels-1:0] channel_mask_t;

endpackage

`default_nettype wire
